// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_rv_core
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps
SOURCES    ?= $(wildcard src/*.sv src/*.svh verif/*.sv)

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+src
src/rv_pkg.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_core_top.sv
verif/tb_rv_core.sv

// ==== src/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// major opcodes, bits [6:0] of the instruction
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011

// alu codes are funct7[5] followed by funct3
`define RV_ALU_ADD    4'b0000
`define RV_ALU_SUB    4'b1000
`define RV_ALU_SLL    4'b0001
`define RV_ALU_SLT    4'b0010
`define RV_ALU_SLTU   4'b0011
`define RV_ALU_XOR    4'b0100
`define RV_ALU_SRL    4'b0101
`define RV_ALU_SRA    4'b1101
`define RV_ALU_OR     4'b0110
`define RV_ALU_AND    4'b0111

// branch conditions, funct3 of the branch opcode
`define RV_BR_EQ      3'b000
`define RV_BR_NE      3'b001
`define RV_BR_LT      3'b100
`define RV_BR_GE      3'b101
`define RV_BR_LTU     3'b110
`define RV_BR_GEU     3'b111

// rv32e register count, matches the 4-bit index
`define RV_NUM_REGS   16

`endif

// ==== src/rv_core_top.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_top (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::inst_t    inst_i,
  input  rv_pkg::word_t    pc_i,
  input  logic             inst_valid_i,
  output logic             inst_ready_o,
  input  logic             retire_ready_i,
  output logic             retire_valid_o,
  output rv_pkg::word_t    retire_pc_o,
  output rv_pkg::reg_idx_t retire_rd_o,
  output logic             retire_wen_o,
  output rv_pkg::word_t    retire_data_o,
  output rv_pkg::word_t    retire_next_pc_o,
  output logic             retire_illegal_o
);
  import rv_pkg::*;

  // register file side
  reg_idx_t                rs1;
  reg_idx_t                rs2;
  word_t                   rdata1;
  word_t                   rdata2;
  logic [`RV_NUM_REGS-1:0] busy;
  logic                    issue_set;
  reg_idx_t                issue_rd;
  logic                    wb_en;
  reg_idx_t                wb_rd;
  word_t                   wb_data;

  // decode to execute
  logic                    dec_valid;
  word_t                   dec_pc;
  reg_idx_t                dec_rd;
  logic                    dec_wen;
  alu_op_t                 dec_alu_op;
  word_t                   dec_op1;
  word_t                   dec_op2;
  logic                    dec_is_branch;
  logic                    dec_is_jump;
  logic [2:0]              dec_br_func;
  word_t                   dec_br_a;
  word_t                   dec_br_b;
  word_t                   dec_target;
  logic                    dec_illegal;
  logic                    exe_ready;

  // execute to result, plus forwarding
  logic                    exe_valid;
  word_t                   exe_pc;
  reg_idx_t                exe_rd;
  logic                    exe_wen;
  word_t                   exe_data;
  word_t                   exe_next_pc;
  logic                    exe_illegal;
  reg_idx_t                exe_fwd_rd;
  word_t                   exe_fwd_data;
  logic                    res_ready;

  rv_regfile u_regfile (
    .clk         (clk),
    .rst         (rst),
    .rs1_i       (rs1),
    .rs2_i       (rs2),
    .rdata1_o    (rdata1),
    .rdata2_o    (rdata2),
    .busy_o      (busy),
    .issue_set_i (issue_set),
    .issue_rd_i  (issue_rd),
    .wb_en_i     (wb_en),
    .wb_rd_i     (wb_rd),
    .wb_data_i   (wb_data)
  );

  rv_decode u_decode (
    .clk             (clk),
    .rst             (rst),
    .inst_i          (inst_i),
    .pc_i            (pc_i),
    .inst_valid_i    (inst_valid_i),
    .inst_ready_o    (inst_ready_o),
    .rs1_o           (rs1),
    .rs2_o           (rs2),
    .rdata1_i        (rdata1),
    .rdata2_i        (rdata2),
    .busy_i          (busy),
    .exe_valid_i     (exe_valid),
    .exe_fwd_rd_i    (exe_fwd_rd),
    .exe_fwd_data_i  (exe_fwd_data),
    .issue_set_o     (issue_set),
    .issue_rd_o      (issue_rd),
    .dec_valid_o     (dec_valid),
    .dec_pc_o        (dec_pc),
    .dec_rd_o        (dec_rd),
    .dec_wen_o       (dec_wen),
    .dec_alu_op_o    (dec_alu_op),
    .dec_op1_o       (dec_op1),
    .dec_op2_o       (dec_op2),
    .dec_is_branch_o (dec_is_branch),
    .dec_is_jump_o   (dec_is_jump),
    .dec_br_func_o   (dec_br_func),
    .dec_br_a_o      (dec_br_a),
    .dec_br_b_o      (dec_br_b),
    .dec_target_o    (dec_target),
    .dec_illegal_o   (dec_illegal),
    .exe_ready_i     (exe_ready)
  );

  rv_execute u_execute (
    .clk             (clk),
    .rst             (rst),
    .dec_valid_i     (dec_valid),
    .dec_pc_i        (dec_pc),
    .dec_rd_i        (dec_rd),
    .dec_wen_i       (dec_wen),
    .dec_alu_op_i    (dec_alu_op),
    .dec_op1_i       (dec_op1),
    .dec_op2_i       (dec_op2),
    .dec_is_branch_i (dec_is_branch),
    .dec_is_jump_i   (dec_is_jump),
    .dec_br_func_i   (dec_br_func),
    .dec_br_a_i      (dec_br_a),
    .dec_br_b_i      (dec_br_b),
    .dec_target_i    (dec_target),
    .dec_illegal_i   (dec_illegal),
    .exe_ready_o     (exe_ready),
    .res_ready_i     (res_ready),
    .exe_valid_o     (exe_valid),
    .exe_pc_o        (exe_pc),
    .exe_rd_o        (exe_rd),
    .exe_wen_o       (exe_wen),
    .exe_data_o      (exe_data),
    .exe_next_pc_o   (exe_next_pc),
    .exe_illegal_o   (exe_illegal),
    .exe_fwd_rd_o    (exe_fwd_rd),
    .exe_fwd_data_o  (exe_fwd_data)
  );

  rv_result u_result (
    .clk              (clk),
    .rst              (rst),
    .exe_valid_i      (exe_valid),
    .exe_pc_i         (exe_pc),
    .exe_rd_i         (exe_rd),
    .exe_wen_i        (exe_wen),
    .exe_data_i       (exe_data),
    .exe_next_pc_i    (exe_next_pc),
    .exe_illegal_i    (exe_illegal),
    .res_ready_o      (res_ready),
    .wb_en_o          (wb_en),
    .wb_rd_o          (wb_rd),
    .wb_data_o        (wb_data),
    .retire_valid_o   (retire_valid_o),
    .retire_pc_o      (retire_pc_o),
    .retire_rd_o      (retire_rd_o),
    .retire_wen_o     (retire_wen_o),
    .retire_data_o    (retire_data_o),
    .retire_next_pc_o (retire_next_pc_o),
    .retire_illegal_o (retire_illegal_o),
    .retire_ready_i   (retire_ready_i)
  );

endmodule

// ==== src/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decode (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pkg::inst_t           inst_i,
  input  rv_pkg::word_t           pc_i,
  input  logic                    inst_valid_i,
  output logic                    inst_ready_o,
  output rv_pkg::reg_idx_t        rs1_o,
  output rv_pkg::reg_idx_t        rs2_o,
  input  rv_pkg::word_t           rdata1_i,
  input  rv_pkg::word_t           rdata2_i,
  input  logic [`RV_NUM_REGS-1:0] busy_i,
  input  logic                    exe_valid_i,
  input  rv_pkg::reg_idx_t        exe_fwd_rd_i,
  input  rv_pkg::word_t           exe_fwd_data_i,
  output logic                    issue_set_o,
  output rv_pkg::reg_idx_t        issue_rd_o,
  output logic                    dec_valid_o,
  output rv_pkg::word_t           dec_pc_o,
  output rv_pkg::reg_idx_t        dec_rd_o,
  output logic                    dec_wen_o,
  output rv_pkg::alu_op_t         dec_alu_op_o,
  output rv_pkg::word_t           dec_op1_o,
  output rv_pkg::word_t           dec_op2_o,
  output logic                    dec_is_branch_o,
  output logic                    dec_is_jump_o,
  output logic [2:0]              dec_br_func_o,
  output rv_pkg::word_t           dec_br_a_o,
  output rv_pkg::word_t           dec_br_b_o,
  output rv_pkg::word_t           dec_target_o,
  output logic                    dec_illegal_o,
  input  logic                    exe_ready_i
);
  import rv_pkg::*;

  inst_t      inst_q;
  word_t      pc_q;
  logic       valid_q;
  logic       ready_q;
  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_idx_t   rd;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  logic       fwd1;
  logic       fwd2;
  word_t      src1;
  word_t      src2;
  logic       use_rs1;
  logic       use_rs2;
  logic       writes;
  logic       hazard;
  logic       accept;
  logic       dec_fire;

  assign opcode = inst_q[6:0];
  assign funct3 = inst_q[14:12];
  assign rd     = inst_q[10:7];
  assign rs1_o  = inst_q[18:15];
  assign rs2_o  = inst_q[23:20];

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};

  // execute only drives a nonzero index when its result writes a register
  assign fwd1 = exe_valid_i && exe_fwd_rd_i != '0 && exe_fwd_rd_i == rs1_o;
  assign fwd2 = exe_valid_i && exe_fwd_rd_i != '0 && exe_fwd_rd_i == rs2_o;
  assign src1 = fwd1 ? exe_fwd_data_i : rdata1_i;
  assign src2 = fwd2 ? exe_fwd_data_i : rdata2_i;

  // a busy rd also stalls, so each register has at most one writer in flight
  assign hazard = valid_q && ((use_rs1 && busy_i[rs1_o] && !fwd1) ||
                              (use_rs2 && busy_i[rs2_o] && !fwd2) ||
                              (dec_wen_o && busy_i[rd]));

  assign dec_valid_o  = valid_q && !hazard;
  assign dec_fire     = dec_valid_o && exe_ready_i;
  assign inst_ready_o = ready_q && (!valid_q || dec_fire);
  assign accept       = inst_valid_i && inst_ready_o;

  assign dec_pc_o      = pc_q;
  assign dec_rd_o      = rd;
  assign dec_br_func_o = funct3;
  assign dec_br_a_o    = src1;
  assign dec_br_b_o    = src2;
  assign dec_wen_o     = writes && rd != '0;
  assign issue_set_o   = dec_fire && dec_wen_o;
  assign issue_rd_o    = rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
      if (accept) begin
        valid_q <= 1'b1;
      end else if (dec_fire) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  // instructions that write nothing leave both operands at zero, so data is zero
  always_comb begin
    dec_alu_op_o    = `RV_ALU_ADD;
    dec_op1_o       = '0;
    dec_op2_o       = '0;
    dec_target_o    = pc_q + imm_b;
    dec_is_branch_o = 1'b0;
    dec_is_jump_o   = 1'b0;
    dec_illegal_o   = 1'b0;
    use_rs1         = 1'b0;
    use_rs2         = 1'b0;
    writes          = 1'b0;
    case (opcode)
      `RV_OP_LUI: begin
        dec_op2_o = imm_u;
        writes    = 1'b1;
      end
      `RV_OP_AUIPC: begin
        dec_op1_o = pc_q;
        dec_op2_o = imm_u;
        writes    = 1'b1;
      end
      `RV_OP_JAL: begin
        dec_op1_o     = pc_q;
        dec_op2_o     = 32'd4;
        dec_target_o  = pc_q + imm_j;
        dec_is_jump_o = 1'b1;
        writes        = 1'b1;
      end
      `RV_OP_JALR: begin
        dec_op1_o     = pc_q;
        dec_op2_o     = 32'd4;
        dec_target_o  = (src1 + imm_i) & ~32'd1;
        dec_is_jump_o = 1'b1;
        use_rs1       = 1'b1;
        writes        = 1'b1;
      end
      `RV_OP_BRANCH: begin
        dec_is_branch_o = 1'b1;
        use_rs1         = 1'b1;
        use_rs2         = 1'b1;
      end
      `RV_OP_IMM: begin
        // funct7[5] only selects sra among the immediate forms
        dec_alu_op_o = {(funct3 == 3'b101) && inst_q[30], funct3};
        dec_op1_o    = src1;
        dec_op2_o    = imm_i;
        use_rs1      = 1'b1;
        writes       = 1'b1;
      end
      `RV_OP_REG: begin
        dec_alu_op_o = {inst_q[30], funct3};
        dec_op1_o    = src1;
        dec_op2_o    = src2;
        use_rs1      = 1'b1;
        use_rs2      = 1'b1;
        writes       = 1'b1;
      end
      default: begin
        dec_illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_execute (
  input  logic             clk,
  input  logic             rst,
  input  logic             dec_valid_i,
  input  rv_pkg::word_t    dec_pc_i,
  input  rv_pkg::reg_idx_t dec_rd_i,
  input  logic             dec_wen_i,
  input  rv_pkg::alu_op_t  dec_alu_op_i,
  input  rv_pkg::word_t    dec_op1_i,
  input  rv_pkg::word_t    dec_op2_i,
  input  logic             dec_is_branch_i,
  input  logic             dec_is_jump_i,
  input  logic [2:0]       dec_br_func_i,
  input  rv_pkg::word_t    dec_br_a_i,
  input  rv_pkg::word_t    dec_br_b_i,
  input  rv_pkg::word_t    dec_target_i,
  input  logic             dec_illegal_i,
  output logic             exe_ready_o,
  input  logic             res_ready_i,
  output logic             exe_valid_o,
  output rv_pkg::word_t    exe_pc_o,
  output rv_pkg::reg_idx_t exe_rd_o,
  output logic             exe_wen_o,
  output rv_pkg::word_t    exe_data_o,
  output rv_pkg::word_t    exe_next_pc_o,
  output logic             exe_illegal_o,
  output rv_pkg::reg_idx_t exe_fwd_rd_o,
  output rv_pkg::word_t    exe_fwd_data_o
);
  import rv_pkg::*;

  word_t      alu_res;
  word_t      next_pc;
  logic [4:0] shamt;
  logic       taken;
  logic       accept;

  assign shamt = dec_op2_i[4:0];

  always_comb begin
    case (dec_alu_op_i)
      `RV_ALU_ADD:  alu_res = dec_op1_i + dec_op2_i;
      `RV_ALU_SUB:  alu_res = dec_op1_i - dec_op2_i;
      `RV_ALU_SLL:  alu_res = dec_op1_i << shamt;
      `RV_ALU_SLT:  alu_res = {31'b0, $signed(dec_op1_i) < $signed(dec_op2_i)};
      `RV_ALU_SLTU: alu_res = {31'b0, dec_op1_i < dec_op2_i};
      `RV_ALU_XOR:  alu_res = dec_op1_i ^ dec_op2_i;
      `RV_ALU_SRL:  alu_res = dec_op1_i >> shamt;
      `RV_ALU_SRA:  alu_res = word_t'($signed(dec_op1_i) >>> shamt);
      `RV_ALU_OR:   alu_res = dec_op1_i | dec_op2_i;
      `RV_ALU_AND:  alu_res = dec_op1_i & dec_op2_i;
      default:      alu_res = dec_op1_i + dec_op2_i;
    endcase
  end

  // funct3 010 and 011 are not branches, never taken
  always_comb begin
    case (dec_br_func_i)
      `RV_BR_EQ:  taken = dec_br_a_i == dec_br_b_i;
      `RV_BR_NE:  taken = dec_br_a_i != dec_br_b_i;
      `RV_BR_LT:  taken = $signed(dec_br_a_i) < $signed(dec_br_b_i);
      `RV_BR_GE:  taken = $signed(dec_br_a_i) >= $signed(dec_br_b_i);
      `RV_BR_LTU: taken = dec_br_a_i < dec_br_b_i;
      `RV_BR_GEU: taken = dec_br_a_i >= dec_br_b_i;
      default:    taken = 1'b0;
    endcase
  end

  assign next_pc = (dec_is_jump_i || (dec_is_branch_i && taken)) ? dec_target_i
                                                                 : dec_pc_i + 32'd4;

  assign exe_ready_o = !exe_valid_o || res_ready_i;
  assign accept      = dec_valid_i && exe_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      exe_valid_o <= 1'b0;
    end else if (accept) begin
      exe_valid_o <= 1'b1;
    end else if (res_ready_i) begin
      exe_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      exe_pc_o      <= dec_pc_i;
      exe_rd_o      <= dec_rd_i;
      exe_wen_o     <= dec_wen_i;
      exe_data_o    <= alu_res;
      exe_next_pc_o <= next_pc;
      exe_illegal_o <= dec_illegal_i;
    end
  end

  // held result is the forward source, index zero means nothing to forward
  assign exe_fwd_rd_o   = exe_wen_o ? exe_rd_o : '0;
  assign exe_fwd_data_o = exe_data_o;

endmodule

// ==== src/rv_pkg.sv ====
package rv_pkg;

  // data word or program counter
  typedef logic [31:0] word_t;

  // register index, rv32e only has x0..x15
  typedef logic [3:0] reg_idx_t;

  // funct7[5] then funct3
  typedef logic [3:0] alu_op_t;

  // raw instruction word
  typedef logic [31:0] inst_t;

endpackage

// ==== src/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_regfile (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_pkg::reg_idx_t        rs1_i,
  input  rv_pkg::reg_idx_t        rs2_i,
  output rv_pkg::word_t           rdata1_o,
  output rv_pkg::word_t           rdata2_o,
  output logic [`RV_NUM_REGS-1:0] busy_o,
  input  logic                    issue_set_i,
  input  rv_pkg::reg_idx_t        issue_rd_i,
  input  logic                    wb_en_i,
  input  rv_pkg::reg_idx_t        wb_rd_i,
  input  rv_pkg::word_t           wb_data_i
);
  import rv_pkg::*;

  // x0 has no storage
  word_t regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (wb_en_i && wb_rd_i != '0) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

  // one bit per register with a write still in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_o <= '0;
    end else begin
      if (wb_en_i) begin
        busy_o[wb_rd_i] <= 1'b0;
      end
      // later assignment, so a new issue beats a retiring write
      if (issue_set_i) begin
        busy_o[issue_rd_i] <= 1'b1;
      end
    end
  end

endmodule

// ==== src/rv_result.sv ====
`timescale 1ns/1ps

module rv_result (
  input  logic             clk,
  input  logic             rst,
  input  logic             exe_valid_i,
  input  rv_pkg::word_t    exe_pc_i,
  input  rv_pkg::reg_idx_t exe_rd_i,
  input  logic             exe_wen_i,
  input  rv_pkg::word_t    exe_data_i,
  input  rv_pkg::word_t    exe_next_pc_i,
  input  logic             exe_illegal_i,
  output logic             res_ready_o,
  output logic             wb_en_o,
  output rv_pkg::reg_idx_t wb_rd_o,
  output rv_pkg::word_t    wb_data_o,
  output logic             retire_valid_o,
  output rv_pkg::word_t    retire_pc_o,
  output rv_pkg::reg_idx_t retire_rd_o,
  output logic             retire_wen_o,
  output rv_pkg::word_t    retire_data_o,
  output rv_pkg::word_t    retire_next_pc_o,
  output logic             retire_illegal_o,
  input  logic             retire_ready_i
);

  logic accept;

  assign res_ready_o = !retire_valid_o || retire_ready_i;
  assign accept      = exe_valid_i && res_ready_o;

  // commit on acceptance, decode sees the value a cycle later
  assign wb_en_o   = accept && exe_wen_i && !exe_illegal_i && exe_rd_i != '0;
  assign wb_rd_o   = exe_rd_i;
  assign wb_data_o = exe_data_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid_o <= 1'b0;
    end else if (accept) begin
      retire_valid_o <= 1'b1;
    end else if (retire_ready_i) begin
      retire_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      retire_pc_o      <= exe_pc_i;
      retire_rd_o      <= exe_rd_i;
      retire_wen_o     <= exe_wen_i && !exe_illegal_i;
      retire_data_o    <= exe_data_i;
      retire_next_pc_o <= exe_next_pc_i;
      retire_illegal_o <= exe_illegal_i;
    end
  end

endmodule

// ==== verif/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module tb_rv_core;
  import rv_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int M_PRELOAD  = 0;
  localparam int M_ALU      = 1;
  localparam int M_DEP      = 2;
  localparam int M_CTRL     = 3;
  localparam int M_BP       = 4;
  localparam int M_ILL      = 5;
  localparam int N_PRELOAD  = 30;
  localparam int N_RANDOM   = 300;
  localparam int N_TOTAL    = N_PRELOAD + 5 * N_RANDOM;
  // gaps, stalls and back-pressure stay well under 20 cycles per instruction
  localparam int WD_CYCLES  = 20 * N_TOTAL + 200;

  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    logic     wen;
    word_t    data;
    word_t    next_pc;
    logic     illegal;
  } retire_rec_t;

  logic        clk = 1'b0;
  logic        rst;
  inst_t       inst_i;
  word_t       pc_i;
  logic        inst_valid_i;
  logic        inst_ready_o;
  logic        retire_ready_i;
  logic        retire_valid_o;
  word_t       retire_pc_o;
  reg_idx_t    retire_rd_o;
  logic        retire_wen_o;
  word_t       retire_data_o;
  word_t       retire_next_pc_o;
  logic        retire_illegal_o;

  logic [31:0] lfsr = 32'he09f;
  word_t       mregs [0:15];
  word_t       preload [1:15];
  retire_rec_t exp_q [$];
  word_t       pc_next = 32'h0000_1000;
  int          issued = 0;
  int          accepted_cnt = 0;
  int          retired_cnt = 0;
  int          err_cnt = 0;
  int          tests_run = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  rv_core_top rv_core_top_i (
    .clk              (clk),
    .rst              (rst),
    .inst_i           (inst_i),
    .pc_i             (pc_i),
    .inst_valid_i     (inst_valid_i),
    .inst_ready_o     (inst_ready_o),
    .retire_ready_i   (retire_ready_i),
    .retire_valid_o   (retire_valid_o),
    .retire_pc_o      (retire_pc_o),
    .retire_rd_o      (retire_rd_o),
    .retire_wen_o     (retire_wen_o),
    .retire_data_o    (retire_data_o),
    .retire_next_pc_o (retire_next_pc_o),
    .retire_illegal_o (retire_illegal_o)
  );

  // galois lfsr with taps 32 22 2 1
  function automatic logic next_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], next_bit()};
    end
    return r;
  endfunction

  // half the picks land on x0..x3 to provoke hazards
  function automatic reg_idx_t pick_reg();
    logic [31:0] r;
    r = rand_bits(5);
    if (r[4]) begin
      return {2'b00, r[1:0]};
    end
    return r[3:0];
  endfunction

  function automatic inst_t u_type(input logic [6:0] op, input reg_idx_t rd,
                                   input logic [19:0] imm);
    return {imm, 1'b0, rd, op};
  endfunction

  function automatic inst_t i_type(input logic [6:0] op, input logic [2:0] f3,
                                   input reg_idx_t rd, input reg_idx_t rs1,
                                   input logic [11:0] imm);
    return {imm, 1'b0, rs1, f3, 1'b0, rd, op};
  endfunction

  function automatic inst_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd);
    return {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, `RV_OP_REG};
  endfunction

  function automatic inst_t b_type(input logic [2:0] f3, input reg_idx_t rs1,
                                   input reg_idx_t rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], 1'b0, rs2, 1'b0, rs1, f3, imm[4:1], imm[11],
            `RV_OP_BRANCH};
  endfunction

  function automatic inst_t j_type(input reg_idx_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 1'b0, rd, `RV_OP_JAL};
  endfunction

  function automatic inst_t make_inst(input int mode, input int n);
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [31:0] k;
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    word_t       v;
    inst_t       inst;
    if (mode == M_PRELOAD) begin
      // lui then addi with the upper part rounded up when the low part is negative
      rd = n[4:1] + 4'd1;
      v  = preload[rd];
      if (n[0]) begin
        return i_type(`RV_OP_IMM, 3'b000, rd, rd, v[11:0]);
      end
      return u_type(`RV_OP_LUI, rd, v[31:12] + {19'b0, v[11]});
    end
    k   = rand_bits(3);
    rd  = pick_reg();
    rs1 = pick_reg();
    rs2 = pick_reg();
    r   = rand_bits(32);
    f3  = r[14:12];
    if (mode == M_ALU) begin
      k = r[16] ? 32'd5 : 32'd6;
    end else if (mode == M_CTRL && k[2]) begin
      k = 32'd4;
    end
    case (k[2:0])
      3'd0: inst = u_type(`RV_OP_LUI, rd, r[19:0]);
      3'd1: inst = u_type(`RV_OP_AUIPC, rd, r[19:0]);
      3'd2: inst = j_type(rd, {r[19:0], 1'b0});
      3'd3: inst = i_type(`RV_OP_JALR, 3'b000, rd, rs1, r[11:0]);
      3'd4: begin
        // funct3 010 and 011 are no branch so they fold onto beq and bne
        if (f3[2:1] == 2'b01) begin
          f3[1] = 1'b0;
        end
        inst = b_type(f3, rs1, rs2, {r[11:0], 1'b0});
      end
      3'd5: begin
        imm = r[11:0];
        if (f3 == 3'b001) begin
          imm = {7'b0, r[4:0]};
        end else if (f3 == 3'b101) begin
          imm = {1'b0, r[10], 5'b0, r[4:0]};
        end
        inst = i_type(`RV_OP_IMM, f3, rd, rs1, imm);
      end
      default: begin
        f7   = ((f3 == 3'b000 || f3 == 3'b101) && r[15]) ? 7'h20 : 7'h00;
        inst = r_type(f7, rs2, rs1, f3, rd);
      end
    endcase
    // load, store, fence and system opcodes
    if (mode == M_ILL && r[31:30] == 2'b00) begin
      case (r[29:28])
        2'd0:    inst[6:0] = 7'b0000011;
        2'd1:    inst[6:0] = 7'b0100011;
        2'd2:    inst[6:0] = 7'b0001111;
        default: inst[6:0] = 7'b1110011;
      endcase
    end
    return inst;
  endfunction

  function automatic word_t alu_result(input logic [2:0] f3, input logic alt,
                                       input word_t a, input word_t b);
    word_t res;
    case (f3)
      3'b000: res = alt ? a - b : a + b;
      3'b001: res = a << b[4:0];
      3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: res = (a < b) ? 32'd1 : 32'd0;
      3'b100: res = a ^ b;
      3'b101: begin
        if (alt) begin
          res = $signed(a) >>> b[4:0];
        end else begin
          res = a >> b[4:0];
        end
      end
      3'b110: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      `RV_BR_EQ:  return a == b;
      `RV_BR_NE:  return a != b;
      `RV_BR_LT:  return $signed(a) < $signed(b);
      `RV_BR_GE:  return $signed(a) >= $signed(b);
      `RV_BR_LTU: return a < b;
      `RV_BR_GEU: return a >= b;
      default:    return 1'b0;
    endcase
  endfunction

  // in-order isa model called once per accepted instruction
  function automatic void model_step(input inst_t inst, input word_t pc);
    word_t       a;
    word_t       b;
    word_t       imm_i;
    word_t       imm_b;
    word_t       imm_u;
    word_t       imm_j;
    logic [2:0]  f3;
    retire_rec_t rec;
    a     = mregs[inst[18:15]];
    b     = mregs[inst[23:20]];
    f3    = inst[14:12];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u = {inst[31:12], 12'b0};
    imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    rec.pc      = pc;
    rec.rd      = inst[10:7];
    rec.wen     = 1'b1;
    rec.data    = '0;
    rec.next_pc = pc + 32'd4;
    rec.illegal = 1'b0;
    case (inst[6:0])
      `RV_OP_LUI:   rec.data = imm_u;
      `RV_OP_AUIPC: rec.data = pc + imm_u;
      `RV_OP_JAL: begin
        rec.data    = pc + 32'd4;
        rec.next_pc = pc + imm_j;
      end
      `RV_OP_JALR: begin
        rec.data    = pc + 32'd4;
        rec.next_pc = (a + imm_i) & ~32'd1;
      end
      `RV_OP_BRANCH: begin
        rec.wen = 1'b0;
        if (branch_taken(f3, a, b)) begin
          rec.next_pc = pc + imm_b;
        end
      end
      `RV_OP_IMM: rec.data = alu_result(f3, f3 == 3'b101 && inst[30], a, imm_i);
      `RV_OP_REG: rec.data = alu_result(f3, inst[30], a, b);
      default: begin
        rec.wen     = 1'b0;
        rec.illegal = 1'b1;
      end
    endcase
    // x0 is never written
    rec.wen = rec.wen && rec.rd != 4'd0;
    if (rec.wen) begin
      mregs[rec.rd] = rec.data;
    end
    exp_q.push_back(rec);
  endfunction

  task automatic report_field(input string name, input word_t got, input word_t want);
    if (got !== want) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, want);
      err_cnt++;
    end
  endtask

  task automatic compare_retire();
    retire_rec_t want;
    retired_cnt++;
    if (exp_q.size() == 0) begin
      $display("retire at %0t with no instruction outstanding, pc %h", $time, retire_pc_o);
      err_cnt++;
    end else begin
      want = exp_q.pop_front();
      report_field("retire_pc_o", retire_pc_o, want.pc);
      report_field("retire_rd_o", {28'b0, retire_rd_o}, {28'b0, want.rd});
      report_field("retire_wen_o", {31'b0, retire_wen_o}, {31'b0, want.wen});
      report_field("retire_data_o", retire_data_o, want.data);
      report_field("retire_next_pc_o", retire_next_pc_o, want.next_pc);
      report_field("retire_illegal_o", {31'b0, retire_illegal_o}, {31'b0, want.illegal});
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      if (retire_valid_o && retire_ready_i) begin
        compare_retire();
      end
      if (inst_valid_i && inst_ready_o) begin
        model_step(inst_i, pc_i);
        accepted_cnt++;
      end
    end
  end

  task automatic run_phase(input string name, input int mode, input int count);
    int          n;
    int          errs_before;
    logic [31:0] r;
    n           = 0;
    errs_before = err_cnt;
    // runs until every accepted instruction has its retire record
    while (n < count || accepted_cnt < issued || exp_q.size() != 0) begin
      @(negedge clk);
      r = '0;
      if (mode == M_BP) begin
        r = rand_bits(3);
      end
      retire_ready_i = (mode != M_BP) || (r[1:0] != 2'b00);
      // a new word only once the previous one is taken
      if (accepted_cnt == issued && n < count && (mode != M_BP || r[2])) begin
        inst_i  = make_inst(mode, n);
        pc_i    = pc_next;
        pc_next = pc_next + 32'd4;
        issued++;
        n++;
      end
      inst_valid_i = (accepted_cnt != issued);
    end
    // the pipeline is empty now, so a pending retire is a duplicate
    if (accepted_cnt != retired_cnt || retire_valid_o) begin
      $display("%s: %0d accepted but %0d retired, extra retire pending %0b",
               name, accepted_cnt, retired_cnt, retire_valid_o);
      err_cnt++;
    end
    tests_run++;
    $display("test %-12s %4d instructions  %0d errors", name, count, err_cnt - errs_before);
  endtask

  initial begin
    rst            = 1'b1;
    inst_i         = '0;
    pc_i           = '0;
    inst_valid_i   = 1'b0;
    retire_ready_i = 1'b0;
    for (int i = 0; i < 16; i++) begin
      mregs[i[3:0]] = '0;
    end
    // edge values for shifts and compares with random values above x5
    preload[1] = 32'h8000_0000;
    preload[2] = 32'h7fff_ffff;
    preload[3] = 32'hffff_ffff;
    preload[4] = 32'h0000_0001;
    preload[5] = 32'h0000_001f;
    for (int i = 6; i < 16; i++) begin
      preload[i[3:0]] = rand_bits(32);
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    run_phase("preload", M_PRELOAD, N_PRELOAD);
    run_phase("alu", M_ALU, N_RANDOM);
    run_phase("dependent", M_DEP, N_RANDOM);
    run_phase("control", M_CTRL, N_RANDOM);
    run_phase("backpressure", M_BP, N_RANDOM);
    run_phase("illegal", M_ILL, N_RANDOM);
    $display("%0d tests, %0d accepted, %0d retired, %0d errors",
             tests_run, accepted_cnt, retired_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, %0d of %0d instructions retired",
             WD_CYCLES, retired_cnt, issued);
    $display("TB FAILED");
    $finish;
  end

endmodule
